//--- include/periph_macros.svh
// Bus widths, address window and UART defaults for the peripheral.
// The window is 64 KB and only address bits [5:2] select a register,
// so the four registers alias across the rest of the window.
// Offsets are word offsets, not byte addresses.
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32

`define PERIPH_BASE 32'h43c0_0000
`define PERIPH_MASK 32'hffff_0000

`define PERIPH_OFF_TXDATA  4'h0
`define PERIPH_OFF_STATUS  4'h1
`define PERIPH_OFF_BAUD    4'h2
`define PERIPH_OFF_SCRATCH 4'h3

`define PERIPH_FIFO_DEPTH 8

// bit time is BAUD_DIV+1 clock cycles
`define PERIPH_BAUD_RST 16'd4

`endif

//--- verilog/periph_pkg.sv
// Types shared by the AXI4-Lite slave, the register file and the UART path.
// Response codes follow AXI4-Lite; only OKAY and SLVERR are produced.
`include "periph_macros.svh"

package periph_pkg;

    typedef logic [`PERIPH_ADDR_W-1:0]   axil_addr_t;
    typedef logic [`PERIPH_DATA_W-1:0]   axil_data_t;
    typedef logic [`PERIPH_DATA_W/8-1:0] axil_strb_t;
    typedef logic [1:0]                  axil_resp_t;
    typedef logic [3:0]                  reg_off_t;
    typedef logic [7:0]                  uart_byte_t;
    typedef logic [15:0]                 baud_div_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        axil_resp_t rresp;
        logic       rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic       wr;
        logic       rd;
        reg_off_t   off;
        axil_data_t wdata;
        axil_strb_t wstrb;
    } reg_cmd_t;

    typedef struct packed {
        axil_data_t rdata;
        logic       err;
    } reg_rsp_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRESP,
        S_RRESP
    } slave_state_e;

endpackage

//--- verilog/tx_fifo.sv
// Synchronous byte FIFO, first-word fall-through on data_o.
// Pushes while full and pops while empty are ignored.
`timescale 1ns/1ps
`include "periph_macros.svh"

module tx_fifo (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   push_i,
    input  periph_pkg::uart_byte_t data_i,
    input  logic                   pop_i,
    output periph_pkg::uart_byte_t data_o,
    output logic                   full_o,
    output logic                   empty_o
);
    import periph_pkg::*;

    localparam int DEPTH = `PERIPH_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    uart_byte_t       mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // both or neither.
            endcase
        end
    end

    assign data_o  = mem_q[rd_ptr_q];
    assign full_o  = count_q == CNT_W'(DEPTH);
    assign empty_o = count_q == '0;

endmodule

//--- verilog/baud_timer.sv
// Bit-time counter. One tick every div_i+1 cycles while enabled.
// Disabling clears the count, so the first tick comes a full bit after enable.
`timescale 1ns/1ps

module baud_timer (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  en_i,
    input  periph_pkg::baud_div_t div_i,
    output logic                  tick_o
);
    import periph_pkg::*;

    baud_div_t cnt_q;

    assign tick_o = en_i && (cnt_q == div_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (!en_i || tick_o) begin
            cnt_q <= '0; // hold or wrap.
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

//--- verilog/uart_tx_shifter.sv
// 8N1 transmitter, LSB first, line idle high.
// Between back-to-back frames the line stays high one extra clock cycle.
// Lowering BAUD_DIV mid-frame below the running count stretches that bit.
`timescale 1ns/1ps

module uart_tx_shifter (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   fifo_empty_i,
    input  periph_pkg::uart_byte_t fifo_data_i,
    output logic                   pop_o,
    input  logic                   tick_i,
    output logic                   timer_en_o,
    output logic                   busy_o,
    output logic                   tx_o
);

    logic [9:0] shift_q;
    logic [3:0] bit_cnt_q;
    logic       busy_q;

    assign pop_o = !busy_q && !fifo_empty_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            shift_q   <= '1;
            bit_cnt_q <= '0;
            busy_q    <= 1'b0;
        end else if (pop_o) begin
            shift_q   <= {1'b1, fifo_data_i, 1'b0}; // stop, data, start.
            bit_cnt_q <= '0;
            busy_q    <= 1'b1;
        end else if (busy_q && tick_i) begin
            shift_q <= {1'b1, shift_q[9:1]}; // ones fill in, line ends high.
            if (bit_cnt_q == 4'd9) begin
                busy_q <= 1'b0;
            end else begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end
    end

    assign timer_en_o = busy_q;
    assign busy_o     = busy_q;
    assign tx_o       = shift_q[0];

endmodule

//--- verilog/periph_regs.sv
// Register file. Answers each command in the same cycle.
// TXDATA reads as 0; a TXDATA write with wstrb[0] clear is accepted but pushes nothing.
// STATUS: bit0 FIFO full, bit1 FIFO empty, bit2 transmitter busy.
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_regs (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  periph_pkg::reg_cmd_t   reg_cmd_i,
    output periph_pkg::reg_rsp_t   reg_rsp_o,
    input  logic                   fifo_full_i,
    input  logic                   fifo_empty_i,
    input  logic                   tx_busy_i,
    output logic                   push_o,
    output periph_pkg::uart_byte_t push_data_o,
    output periph_pkg::baud_div_t  baud_div_o
);
    import periph_pkg::*;

    baud_div_t  baud_q;
    axil_data_t scratch_q;
    axil_data_t status_w;
    logic       access;

    assign access   = reg_cmd_i.wr || reg_cmd_i.rd;
    assign status_w = axil_data_t'({tx_busy_i, fifo_empty_i, fifo_full_i});

    always_comb begin
        reg_rsp_o = '0;
        push_o    = 1'b0;
        case (reg_cmd_i.off)
            `PERIPH_OFF_TXDATA: begin
                reg_rsp_o.err = reg_cmd_i.wr && fifo_full_i; // byte is dropped.
                push_o        = reg_cmd_i.wr && !fifo_full_i && reg_cmd_i.wstrb[0];
            end
            `PERIPH_OFF_STATUS: begin
                reg_rsp_o.rdata = status_w;
                reg_rsp_o.err   = reg_cmd_i.wr; // read only.
            end
            `PERIPH_OFF_BAUD:    reg_rsp_o.rdata = axil_data_t'(baud_q);
            `PERIPH_OFF_SCRATCH: reg_rsp_o.rdata = scratch_q;
            default:             reg_rsp_o.err   = access;
        endcase
        if (reg_rsp_o.err) begin
            reg_rsp_o.rdata = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            baud_q    <= `PERIPH_BAUD_RST;
            scratch_q <= '0;
        end else if (reg_cmd_i.wr) begin
            if (reg_cmd_i.off == `PERIPH_OFF_BAUD) begin
                for (int i = 0; i < $bits(baud_div_t) / 8; i++) begin
                    if (reg_cmd_i.wstrb[i]) begin
                        baud_q[i*8 +: 8] <= reg_cmd_i.wdata[i*8 +: 8];
                    end
                end
            end
            if (reg_cmd_i.off == `PERIPH_OFF_SCRATCH) begin
                for (int i = 0; i < $bits(axil_strb_t); i++) begin
                    if (reg_cmd_i.wstrb[i]) begin
                        scratch_q[i*8 +: 8] <= reg_cmd_i.wdata[i*8 +: 8];
                    end
                end
            end
        end
    end

    assign push_data_o = reg_cmd_i.wdata[7:0];
    assign baud_div_o  = baud_q;

endmodule

//--- verilog/axil_slave_fsm.sv
// AXI4-Lite slave for a single 64 KB window, one transaction at a time.
// A write needs awvalid and wvalid together; awready/wready rise with them.
// Reads wait while any write channel is valid, so writes win.
// Out-of-window accesses never reach the register file and get SLVERR.
`timescale 1ns/1ps
`include "periph_macros.svh"

module axil_slave_fsm (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  periph_pkg::axil_req_t axil_req_i,
    output periph_pkg::axil_rsp_t axil_rsp_o,
    output periph_pkg::reg_cmd_t  reg_cmd_o,
    input  periph_pkg::reg_rsp_t  reg_rsp_i
);
    import periph_pkg::*;

    slave_state_e state_q;
    slave_state_e state_d;
    logic         wr_acc;
    logic         rd_acc;
    logic         aw_hit;
    logic         ar_hit;
    axil_resp_t   bresp_q;
    axil_resp_t   rresp_q;
    axil_data_t   rdata_q;

    assign aw_hit = (axil_req_i.awaddr & `PERIPH_MASK) == `PERIPH_BASE;
    assign ar_hit = (axil_req_i.araddr & `PERIPH_MASK) == `PERIPH_BASE;

    assign wr_acc = (state_q == S_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
    assign rd_acc = (state_q == S_IDLE) && axil_req_i.arvalid
                    && !axil_req_i.awvalid && !axil_req_i.wvalid; // write first.

    always_comb begin
        reg_cmd_o.wr    = wr_acc && aw_hit;
        reg_cmd_o.rd    = rd_acc && ar_hit;
        reg_cmd_o.off   = wr_acc ? axil_req_i.awaddr[5:2] : axil_req_i.araddr[5:2];
        reg_cmd_o.wdata = axil_req_i.wdata;
        reg_cmd_o.wstrb = axil_req_i.wstrb;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (wr_acc) begin
                    state_d = S_WRESP;
                end else if (rd_acc) begin
                    state_d = S_RRESP;
                end
            end
            S_WRESP: begin
                if (axil_req_i.bready) begin
                    state_d = S_IDLE;
                end
            end
            S_RRESP: begin
                if (axil_req_i.rready) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // response held until the master takes it.
    always_ff @(posedge clk_i) begin
        if (wr_acc) begin
            bresp_q <= (aw_hit && !reg_rsp_i.err) ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_acc) begin
            rresp_q <= (ar_hit && !reg_rsp_i.err) ? RESP_OKAY : RESP_SLVERR;
            rdata_q <= (ar_hit && !reg_rsp_i.err) ? reg_rsp_i.rdata : '0;
        end
    end

    always_comb begin
        axil_rsp_o.awready = wr_acc;
        axil_rsp_o.wready  = wr_acc;
        axil_rsp_o.bresp   = bresp_q;
        axil_rsp_o.bvalid  = state_q == S_WRESP;
        axil_rsp_o.arready = rd_acc;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = rresp_q;
        axil_rsp_o.rvalid  = state_q == S_RRESP;
    end

endmodule

//--- verilog/periph_top.sv
// UART transmitter peripheral behind one AXI4-Lite slave port.
// Single clock domain; the master must run on clk_i.
`timescale 1ns/1ps

module periph_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  periph_pkg::axil_req_t axil_req_i,
    output periph_pkg::axil_rsp_t axil_rsp_o,
    output logic                  uart_tx_o
);
    import periph_pkg::*;

    reg_cmd_t   reg_cmd;
    reg_rsp_t   reg_rsp;
    logic       push;
    uart_byte_t push_data;
    baud_div_t  baud_div;
    logic       fifo_full;
    logic       fifo_empty;
    uart_byte_t fifo_data;
    logic       pop;
    logic       tick;
    logic       timer_en;
    logic       tx_busy;

    axil_slave_fsm i_axil_slave_fsm (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .axil_req_i(axil_req_i),
        .axil_rsp_o(axil_rsp_o),
        .reg_cmd_o (reg_cmd),
        .reg_rsp_i (reg_rsp)
    );

    periph_regs i_periph_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .reg_cmd_i   (reg_cmd),
        .reg_rsp_o   (reg_rsp),
        .fifo_full_i (fifo_full),
        .fifo_empty_i(fifo_empty),
        .tx_busy_i   (tx_busy),
        .push_o      (push),
        .push_data_o (push_data),
        .baud_div_o  (baud_div)
    );

    tx_fifo i_tx_fifo (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .push_i (push),
        .data_i (push_data),
        .pop_i  (pop),
        .data_o (fifo_data),
        .full_o (fifo_full),
        .empty_o(fifo_empty)
    );

    baud_timer i_baud_timer (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .en_i   (timer_en),
        .div_i  (baud_div),
        .tick_o (tick)
    );

    uart_tx_shifter i_uart_tx_shifter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .fifo_empty_i(fifo_empty),
        .fifo_data_i (fifo_data),
        .pop_o       (pop),
        .tick_i      (tick),
        .timer_en_o  (timer_en),
        .busy_o      (tx_busy),
        .tx_o        (uart_tx_o)
    );

endmodule

//--- test/tb_periph_top.sv
// Testbench for the AXI4-Lite UART peripheral.
// Random bus traffic from a fixed-seed LFSR is checked against a register and byte-queue model.
// A line monitor decodes every frame at the model's divider, so BAUD_DIV
// is only rewritten while the transmitter is idle.
`timescale 1ns/1ps
`include "periph_macros.svh"

module tb_periph_top;
    import periph_pkg::*;

    localparam int FULL_DIV       = 200;
    localparam int SERIAL_BURSTS  = 3;
    localparam int SERIAL_DIV_MAX = 8;
    localparam int FULL_CYCLES    = (`PERIPH_FIFO_DEPTH + 1) * 10 * (FULL_DIV + 1);
    localparam int SERIAL_CYCLES  = SERIAL_BURSTS * `PERIPH_FIFO_DEPTH * 10 * (SERIAL_DIV_MAX + 1);
    localparam int TIMEOUT_CYCLES = FULL_CYCLES + SERIAL_CYCLES + 5000; // margin for bus traffic.

    logic        clk;
    logic        rst_n;
    axil_req_t   req;
    axil_rsp_t   rsp;
    logic        uart_tx;
    logic [31:0] lfsr_q;
    int          cycle_cnt;
    int          value_errs;
    int          other_errs;
    int          frames;
    axil_data_t  scratch_model;
    baud_div_t   baud_model;
    uart_byte_t  exp_q [$];

    periph_top dut_i (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .axil_req_i(req),
        .axil_rsp_o(rsp),
        .uart_tx_o (uart_tx)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            val    = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    function automatic axil_data_t merge_strobes(input axil_data_t old, input axil_data_t data,
                                                 input axil_strb_t strb);
        axil_data_t res;
        res = old;
        for (int i = 0; i < $bits(axil_strb_t); i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // upper window bits are random, the registers alias there.
    function automatic axil_addr_t window_addr(input reg_off_t off);
        return {16'(`PERIPH_BASE >> 16), 10'(random_bits(10)), off, 2'b00};
    endfunction

    function automatic axil_addr_t outside_addr(input reg_off_t off);
        logic [15:0] upper;
        upper = random_bits(16);
        if (upper == 16'(`PERIPH_BASE >> 16)) begin
            upper[0] = ~upper[0];
        end
        return {upper, 10'(random_bits(10)), off, 2'b00};
    endfunction

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        value_errs++;
        $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic fail_note(input string what);
        other_errs++;
        $display("error: %s", what);
    endtask

    // called and left on a falling edge.
    task automatic write_word(input axil_addr_t addr, input axil_data_t data,
                              input axil_strb_t strb, output axil_resp_t resp);
        req.awaddr  = addr;
        req.awvalid = 1'b1;
        req.wdata   = data;
        req.wstrb   = strb;
        req.wvalid  = 1'b1;
        @(posedge clk); // acceptance cycle.
        if (!(rsp.awready && rsp.wready)) fail_note("awready and wready not raised for the write");
        @(negedge clk);
        while (!rsp.bvalid) @(negedge clk);
        if (rsp.awready || rsp.wready) fail_note("write accepted again while bvalid waits");
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        resp        = rsp.bresp;
        repeat (random_bits(2)) @(negedge clk);
        req.bready = 1'b1;
        @(negedge clk);
        req.bready = 1'b0;
        if (rsp.bvalid) fail_note("bvalid still high after the write response was taken");
    endtask

    task automatic read_word(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_t resp);
        req.araddr  = addr;
        req.arvalid = 1'b1;
        @(posedge clk);
        if (!rsp.arready) fail_note("arready not raised for the read");
        @(negedge clk);
        while (!rsp.rvalid) @(negedge clk);
        if (rsp.arready) fail_note("read accepted again while rvalid waits");
        req.arvalid = 1'b0;
        data        = rsp.rdata;
        resp        = rsp.rresp;
        repeat (random_bits(2)) @(negedge clk);
        req.rready = 1'b1;
        @(negedge clk);
        req.rready = 1'b0;
        if (rsp.rvalid) fail_note("rvalid still high after the read data was taken");
    endtask

    task automatic wait_tx_idle();
        axil_data_t st;
        axil_resp_t resp;
        st = '0;
        while (st[2:1] != 2'b01) begin // wait for empty and not busy.
            repeat (8) @(negedge clk);
            read_word(window_addr(`PERIPH_OFF_STATUS), st, resp);
            if (resp !== RESP_OKAY) mismatch("status poll resp", RESP_OKAY, resp);
        end
    endtask

    // samples mid-bit on falling clock edges.
    initial begin
        int         bit_t;
        uart_byte_t got;
        uart_byte_t want;
        forever begin
            @(negedge uart_tx);
            bit_t = int'(baud_model) + 1;
            repeat (bit_t / 2 + 1) @(negedge clk);
            if (uart_tx !== 1'b0) fail_note("start bit not low at mid bit");
            for (int i = 0; i < 8; i++) begin
                repeat (bit_t) @(negedge clk);
                got[i] = uart_tx;
            end
            repeat (bit_t) @(negedge clk);
            if (uart_tx !== 1'b1) fail_note("stop bit not high at mid bit");
            frames++;
            if (exp_q.size() == 0) begin
                fail_note("frame on the serial line with no byte pending");
            end else begin
                want = exp_q.pop_front();
                if (got !== want) mismatch("serial data", want, got);
            end
        end
    end

    initial begin
        axil_resp_t resp;
        axil_data_t data;
        axil_data_t wdata;
        axil_data_t exp;
        axil_strb_t strb;
        reg_off_t   off;
        int         nbytes;
        clk           = 1'b0;
        rst_n         = 1'b0;
        req           = '0;
        lfsr_q        = 32'h611fff59;
        cycle_cnt     = 0;
        value_errs    = 0;
        other_errs    = 0;
        frames        = 0;
        scratch_model = '0;
        baud_model    = `PERIPH_BAUD_RST;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        if (uart_tx !== 1'b1) mismatch("reset uart_tx", 1, uart_tx);
        if (rsp.awready || rsp.wready || rsp.arready || rsp.bvalid || rsp.rvalid) begin
            fail_note("ready or valid output high after reset");
        end
        read_word(window_addr(`PERIPH_OFF_BAUD), data, resp);
        if (resp !== RESP_OKAY) mismatch("reset baud resp", RESP_OKAY, resp);
        if (data !== 32'(`PERIPH_BAUD_RST)) mismatch("reset baud", `PERIPH_BAUD_RST, data);
        read_word(window_addr(`PERIPH_OFF_SCRATCH), data, resp);
        if (resp !== RESP_OKAY) mismatch("reset scratch resp", RESP_OKAY, resp);
        if (data !== 32'd0) mismatch("reset scratch", 0, data);
        read_word(window_addr(`PERIPH_OFF_STATUS), data, resp);
        if (resp !== RESP_OKAY) mismatch("reset status resp", RESP_OKAY, resp);
        if (data !== 32'h2) mismatch("reset status", 32'h2, data);

        for (int n = 0; n < 40; n++) begin
            off = random_bits(1) ? `PERIPH_OFF_SCRATCH : `PERIPH_OFF_BAUD;
            if (random_bits(1)) begin
                wdata = random_bits(32);
                strb  = random_bits(4);
                write_word(window_addr(off), wdata, strb, resp);
                if (resp !== RESP_OKAY) mismatch("traffic write resp", RESP_OKAY, resp);
                if (off == `PERIPH_OFF_SCRATCH) begin
                    scratch_model = merge_strobes(scratch_model, wdata, strb);
                end else begin
                    baud_model = baud_div_t'(merge_strobes(32'(baud_model), wdata, strb));
                end
            end else begin
                read_word(window_addr(off), data, resp);
                if (resp !== RESP_OKAY) mismatch("traffic read resp", RESP_OKAY, resp);
                exp = (off == `PERIPH_OFF_SCRATCH) ? scratch_model : 32'(baud_model);
                if (data !== exp) mismatch("traffic read", exp, data);
            end
        end

        write_word(outside_addr(`PERIPH_OFF_SCRATCH), random_bits(32), 4'hf, resp);
        if (resp !== RESP_SLVERR) mismatch("outside write resp", RESP_SLVERR, resp);
        read_word(outside_addr(`PERIPH_OFF_SCRATCH), data, resp);
        if (resp !== RESP_SLVERR) mismatch("outside read resp", RESP_SLVERR, resp);
        if (data !== 32'd0) mismatch("outside read data", 0, data);
        for (int n = 0; n < 6; n++) begin
            off = reg_off_t'(4 + random_bits(4) % 12); // offsets 4 to 15.
            write_word(window_addr(off), random_bits(32), 4'hf, resp);
            if (resp !== RESP_SLVERR) mismatch("unmapped write resp", RESP_SLVERR, resp);
            read_word(window_addr(off), data, resp);
            if (resp !== RESP_SLVERR) mismatch("unmapped read resp", RESP_SLVERR, resp);
            if (data !== 32'd0) mismatch("unmapped read data", 0, data);
        end
        write_word(window_addr(`PERIPH_OFF_STATUS), random_bits(32), 4'hf, resp);
        if (resp !== RESP_SLVERR) mismatch("status write resp", RESP_SLVERR, resp);
        read_word(window_addr(`PERIPH_OFF_SCRATCH), data, resp);
        if (data !== scratch_model) mismatch("scratch after errors", scratch_model, data);
        read_word(window_addr(`PERIPH_OFF_BAUD), data, resp);
        if (data !== 32'(baud_model)) mismatch("baud after errors", baud_model, data);

        for (int b = 0; b < SERIAL_BURSTS; b++) begin
            wdata = 32'(random_bits(3) + 1);
            write_word(window_addr(`PERIPH_OFF_BAUD), wdata, 4'b0011, resp);
            if (resp !== RESP_OKAY) mismatch("serial baud resp", RESP_OKAY, resp);
            baud_model = wdata[15:0];
            nbytes     = random_bits(3) + 1;
            for (int n = 0; n < nbytes; n++) begin
                wdata = random_bits(32);
                strb  = random_bits(4);
                write_word(window_addr(`PERIPH_OFF_TXDATA), wdata, strb, resp);
                if (resp !== RESP_OKAY) mismatch("txdata resp", RESP_OKAY, resp);
                if (strb[0]) exp_q.push_back(wdata[7:0]);
            end
            wait_tx_idle();
            if (exp_q.size() != 0) fail_note("bytes of a burst missing on the serial line");
        end

        write_word(window_addr(`PERIPH_OFF_BAUD), FULL_DIV, 4'b0011, resp);
        if (resp !== RESP_OKAY) mismatch("full baud resp", RESP_OKAY, resp);
        baud_model = FULL_DIV;
        // the shifter takes the first byte at once, so depth+1 writes fit.
        for (int n = 0; n <= `PERIPH_FIFO_DEPTH + 1; n++) begin
            wdata = random_bits(32);
            write_word(window_addr(`PERIPH_OFF_TXDATA), wdata, 4'hf, resp);
            if (n <= `PERIPH_FIFO_DEPTH) begin
                if (resp !== RESP_OKAY) mismatch("fill write resp", RESP_OKAY, resp);
                exp_q.push_back(wdata[7:0]);
            end else begin
                if (resp !== RESP_SLVERR) mismatch("overflow write resp", RESP_SLVERR, resp);
            end
        end
        read_word(window_addr(`PERIPH_OFF_STATUS), data, resp);
        if (data !== 32'h5) mismatch("status when full", 32'h5, data);
        wait_tx_idle();
        read_word(window_addr(`PERIPH_OFF_STATUS), data, resp);
        if (data !== 32'h2) mismatch("status when drained", 32'h2, data);
        if (exp_q.size() != 0) fail_note("bytes of the full FIFO missing on the serial line");

        repeat (4) @(negedge clk);
        $display("errors: %0d value, %0d other; frames received: %0d",
                 value_errs, other_errs, frames);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
verilog/periph_pkg.sv
verilog/tx_fifo.sv
verilog/baud_timer.sv
verilog/uart_tx_shifter.sv
verilog/periph_regs.sv
verilog/axil_slave_fsm.sv
verilog/periph_top.sv
test/tb_periph_top.sv

//--- Bender.yml
package:
  name: periph_uart

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/periph_pkg.sv
      - verilog/tx_fifo.sv
      - verilog/baud_timer.sv
      - verilog/uart_tx_shifter.sv
      - verilog/periph_regs.sv
      - verilog/axil_slave_fsm.sv
      - verilog/periph_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_periph_top.sv
